// ==== hw/cam_cfg_pkg.sv ====
package cam_cfg_pkg;

    // 7-bit camera device address, write bit appended on the bus
    localparam logic [7:0] CAM_SLAVE_ADDR = 8'h21;

    // register table rom
    localparam int ROM_ADDR_W = 8;
    localparam int ROM_DATA_W = 16;
    // table terminator word
    localparam logic [ROM_DATA_W-1:0] ROM_END_MARK = 16'hFFFF;

    // serial clock timing, cycles per half period
    localparam int SCL_HALF = 4;
    localparam int SCL_CNT_W = $clog2(SCL_HALF);

    // three phases of nine bits each
    // slave addr, register, value
    localparam int SCCB_PHASES = 3;
    localparam int SCCB_PHASE_W = $clog2(SCCB_PHASES);
    // eight data bits plus ack slot
    localparam int SCCB_BITS = 9;
    localparam int SCCB_BIT_W = $clog2(SCCB_BITS);

    // command buffer between sequencer and master
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // one sccb write command
    typedef struct packed {
        logic [6:0] addr_slave;
        logic [7:0] addr_reg;
        logic [7:0] wr_data;
    } t_sccb_cmd;

endpackage

// ==== hw/cam_cfg_rom.sv ====
`timescale 1ns/10ps

module cam_cfg_rom (
    input  logic                               i_clk,
    input  logic [cam_cfg_pkg::ROM_ADDR_W-1:0] i_addr,
    output logic [cam_cfg_pkg::ROM_DATA_W-1:0] o_data
);
    import cam_cfg_pkg::*;

    // entries are {register, value}
    // registered output, one cycle from address to data
    always_ff @(posedge i_clk) begin
        case (i_addr)
            // soft reset of all registers
            8'd0:    o_data <= 16'h1280;
            // clock prescaler
            8'd1:    o_data <= 16'h1101;
            // scaling enable
            8'd2:    o_data <= 16'h0C04;
            // pclk divider and manual scaling
            8'd3:    o_data <= 16'h3E19;
            // horizontal scale, test pattern off
            8'd4:    o_data <= 16'h703A;
            // vertical scale
            8'd5:    o_data <= 16'h7135;
            // downsample by two
            8'd6:    o_data <= 16'h7211;
            // dsp clock divider
            8'd7:    o_data <= 16'h73F1;
            // pixel clock delay
            8'd8:    o_data <= 16'hA202;
            // rgb output format
            8'd9:    o_data <= 16'h1204;
            // rgb565, full output range
            8'd10:   o_data <= 16'h40D0;
            // rgb444 off
            8'd11:   o_data <= 16'h8C00;
            // end of table, also anything past it
            default: o_data <= ROM_END_MARK;
        endcase
    end

endmodule

// ==== hw/cam_cfg_seq.sv ====
`timescale 1ns/10ps

module cam_cfg_seq (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_start,
    output logic [cam_cfg_pkg::ROM_ADDR_W-1:0] o_rom_addr,
    input  logic [cam_cfg_pkg::ROM_DATA_W-1:0] i_rom_data,
    output logic                               o_cmd_valid,
    output cam_cfg_pkg::t_sccb_cmd             o_cmd,
    input  logic                               i_cmd_ready,
    input  logic                               i_bus_idle,
    output logic                               o_busy,
    output logic                               o_done
);
    import cam_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_ISSUE,
        ST_DRAIN
    } t_state;

    t_state state;
    // high for the cycle the rom still latches the new address
    logic   rom_wait;
    logic   rom_ready;
    logic   load_cmd;

    assign rom_ready = (state == ST_FETCH) && !rom_wait;
    // table word turns into a command unless it is the terminator
    assign load_cmd  = rom_ready && (i_rom_data != ROM_END_MARK);
    assign o_busy    = (state != ST_IDLE);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= ST_IDLE;
            rom_wait    <= 1'b0;
            o_rom_addr  <= '0;
            o_cmd_valid <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // start strobe only counts here
                    if (i_start) begin
                        o_rom_addr <= '0;
                        rom_wait   <= 1'b1;
                        state      <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    rom_wait <= 1'b0;
                    if (load_cmd) begin
                        o_cmd_valid <= 1'b1;
                        state       <= ST_ISSUE;
                    end else if (rom_ready) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_ISSUE: begin
                    // hold until the fifo takes it, then step the table
                    if (i_cmd_ready) begin
                        o_cmd_valid <= 1'b0;
                        o_rom_addr  <= o_rom_addr + 1'b1;
                        rom_wait    <= 1'b1;
                        state       <= ST_FETCH;
                    end
                end
                ST_DRAIN: begin
                    // wait for fifo empty and master back in idle
                    if (i_bus_idle) begin
                        o_done <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload captured once per table entry
    always_ff @(posedge i_clk) begin
        if (load_cmd) begin
            o_cmd.addr_slave <= CAM_SLAVE_ADDR[6:0];
            o_cmd.addr_reg   <= i_rom_data[15:8];
            o_cmd.wr_data    <= i_rom_data[7:0];
        end
    end

    // stalled command keeps its valid and payload
    a_cmd_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        o_cmd_valid && !i_cmd_ready |=> o_cmd_valid && $stable(o_cmd));

    // done only once the command stream is finished
    a_done_no_cmd: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_done && o_cmd_valid));

endmodule

// ==== hw/cmd_fifo.sv ====
`timescale 1ns/10ps

module cmd_fifo #(
    parameter type T_PAYLOAD = logic [7:0]
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_wr_valid,
    input  T_PAYLOAD i_wr_data,
    output logic     o_wr_ready,
    output logic     o_rd_valid,
    output T_PAYLOAD o_rd_data,
    input  logic     i_rd_ready,
    output logic     o_empty
);
    import cam_cfg_pkg::*;

    T_PAYLOAD              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  wr_en;
    logic                  rd_en;

    // full is the only back-pressure
    assign o_wr_ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign o_empty    = (count == '0);
    assign o_rd_valid = !o_empty;
    // show-ahead read port
    assign o_rd_data  = mem[rd_ptr];

    assign wr_en = i_wr_valid && o_wr_ready;
    assign rd_en = o_rd_valid && i_rd_ready;

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at depth, need not be a power of two
            if (wr_en) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // count never runs past the depth
    a_no_write_full: assert property (@(posedge i_clk) disable iff (i_rst)
        count <= FIFO_CNT_W'(FIFO_DEPTH));

    // empty fifo has both pointers together
    a_no_read_empty: assert property (@(posedge i_clk) disable iff (i_rst)
        count == '0 |-> wr_ptr == rd_ptr);

endmodule

// ==== hw/sccb_master.sv ====
`timescale 1ns/10ps

module sccb_master (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_cmd_valid,
    input  cam_cfg_pkg::t_sccb_cmd i_cmd,
    output logic                   o_cmd_ready,
    input  logic                   i_clear,
    output logic                   o_idle,
    output logic                   o_nack,
    output logic                   o_scl_oe,
    output logic                   o_sda_oe,
    input  logic                   i_sda
);
    import cam_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_BITS,
        ST_STOP
    } t_state;

    t_state                  state;
    t_sccb_cmd               cmd_q;
    logic [SCL_CNT_W-1:0]    cnt;
    logic [SCCB_BIT_W-1:0]   bit_cnt;
    logic [SCCB_PHASE_W-1:0] phase;
    logic [7:0]              cur_byte;
    logic                    cur_bit;
    logic                    half_end;
    logic                    half_mid;
    logic                    ack_slot;

    // one command at a time, taken only from idle
    assign o_cmd_ready = (state == ST_IDLE);
    assign o_idle      = (state == ST_IDLE);

    assign half_end = (cnt == SCL_CNT_W'(SCL_HALF - 1));
    // data moves mid-low, ack sampled mid-high
    assign half_mid = (cnt == SCL_CNT_W'(SCL_HALF / 2 - 1));
    assign ack_slot = (bit_cnt == SCCB_BIT_W'(SCCB_BITS - 1));

    // byte for the current phase, write bit is zero
    always_comb begin
        case (phase)
            SCCB_PHASE_W'(0): cur_byte = {cmd_q.addr_slave, 1'b0};
            SCCB_PHASE_W'(1): cur_byte = cmd_q.addr_reg;
            default:          cur_byte = cmd_q.wr_data;
        endcase
    end

    // msb first
    assign cur_bit = cur_byte[3'd7 - bit_cnt[2:0]];

    always_ff @(posedge i_clk) begin
        if (i_cmd_valid && o_cmd_ready) begin
            cmd_q <= i_cmd;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            bit_cnt  <= '0;
            phase    <= '0;
            o_scl_oe <= 1'b0;
            o_sda_oe <= 1'b0;
            o_nack   <= 1'b0;
        end else begin
            // sticky until the next accepted start
            if (i_clear) begin
                o_nack <= 1'b0;
            end
            cnt <= (state == ST_IDLE || half_end) ? '0 : cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    // start condition, sda falls with scl released
                    if (i_cmd_valid) begin
                        o_sda_oe <= 1'b1;
                        state    <= ST_START;
                    end
                end
                ST_START: begin
                    if (half_end) begin
                        o_scl_oe <= 1'b1;
                        bit_cnt  <= '0;
                        phase    <= '0;
                        state    <= ST_BITS;
                    end
                end
                ST_BITS: begin
                    if (o_scl_oe) begin
                        // low half
                        // ack slot releases the line for the camera
                        if (half_mid) begin
                            o_sda_oe <= ack_slot ? 1'b0 : !cur_bit;
                        end
                        if (half_end) begin
                            o_scl_oe <= 1'b0;
                        end
                    end else begin
                        // high half
                        if (half_mid && ack_slot && i_sda) begin
                            o_nack <= 1'b1;
                        end
                        if (half_end) begin
                            o_scl_oe <= 1'b1;
                            if (ack_slot) begin
                                bit_cnt <= '0;
                                if (phase == SCCB_PHASE_W'(SCCB_PHASES - 1)) begin
                                    state <= ST_STOP;
                                end else begin
                                    phase <= phase + 1'b1;
                                end
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                ST_STOP: begin
                    if (o_scl_oe) begin
                        // pull sda low before scl rises
                        if (half_mid) begin
                            o_sda_oe <= 1'b1;
                        end
                        if (half_end) begin
                            o_scl_oe <= 1'b0;
                        end
                    end else begin
                        // stop condition, sda rises while scl high
                        if (half_mid) begin
                            o_sda_oe <= 1'b0;
                        end
                        if (half_end) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // sda steady while scl is high, start and stop excepted
    a_sda_on_scl_low: assert property (@(posedge i_clk) disable iff (i_rst)
        !o_scl_oe && !$past(o_scl_oe) && $changed(o_sda_oe)
        |-> state inside {ST_START, ST_STOP});

endmodule

// ==== hw/cam_cfg_top.sv ====
`timescale 1ns/10ps

module cam_cfg_top (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_start,
    input  logic i_sda,
    output logic o_scl_oe,
    output logic o_sda_oe,
    output logic o_busy,
    output logic o_done,
    output logic o_nack
);
    import cam_cfg_pkg::*;

    logic [ROM_ADDR_W-1:0] s_rom_addr;
    logic [ROM_DATA_W-1:0] s_rom_data;
    logic                  s_cmd_valid;
    logic                  s_cmd_ready;
    t_sccb_cmd             s_cmd;
    logic                  s_q_valid;
    logic                  s_q_ready;
    t_sccb_cmd             s_q_cmd;
    logic                  s_fifo_empty;
    logic                  s_master_idle;
    logic                  s_bus_idle;
    logic                  s_start_acc;

    // start only counts while not busy, same gate as the sequencer
    assign s_start_acc = i_start && !o_busy;
    // nothing queued and nothing on the wire
    assign s_bus_idle  = s_master_idle && s_fifo_empty;

    cam_cfg_rom inst_cam_cfg_rom (
        .i_clk  (i_clk),
        .i_addr (s_rom_addr),
        .o_data (s_rom_data)
    );

    cam_cfg_seq inst_cam_cfg_seq (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .o_rom_addr  (s_rom_addr),
        .i_rom_data  (s_rom_data),
        .o_cmd_valid (s_cmd_valid),
        .o_cmd       (s_cmd),
        .i_cmd_ready (s_cmd_ready),
        .i_bus_idle  (s_bus_idle),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    cmd_fifo #(
        .T_PAYLOAD (t_sccb_cmd)
    ) inst_cmd_fifo (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_wr_valid (s_cmd_valid),
        .i_wr_data  (s_cmd),
        .o_wr_ready (s_cmd_ready),
        .o_rd_valid (s_q_valid),
        .o_rd_data  (s_q_cmd),
        .i_rd_ready (s_q_ready),
        .o_empty    (s_fifo_empty)
    );

    sccb_master inst_sccb_master (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_cmd_valid (s_q_valid),
        .i_cmd       (s_q_cmd),
        .o_cmd_ready (s_q_ready),
        .i_clear     (s_start_acc),
        .o_idle      (s_master_idle),
        .o_nack      (o_nack),
        .o_scl_oe    (o_scl_oe),
        .o_sda_oe    (o_sda_oe),
        .i_sda       (i_sda)
    );

endmodule

// ==== sim/tb_cam_cfg.sv ====
`timescale 1ns/10ps

module tb_cam_cfg;
    import cam_cfg_pkg::*;

    logic clk;
    logic i_rst;
    logic i_start;
    logic i_sda;
    wire  o_scl_oe;
    wire  o_sda_oe;
    wire  o_busy;
    wire  o_done;
    wire  o_nack;

    // stimulus from the input file
    int         run_nack[$];
    bit         run_busy[$];
    logic [7:0] exp_reg[$];
    logic [7:0] exp_val[$];

    // decoded bus writes, {slave byte, register, value}
    logic [23:0] txn_q[$];

    int          mismatch_count = 0;
    int          other_count = 0;
    int          done_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    bit          first_start_sent = 1'b0;
    logic [31:0] lfsr_state = 32'hd01a;

    // slave model state
    logic       scl_now;
    logic       sda_now;
    logic       scl_prev = 1'b1;
    logic       sda_prev = 1'b1;
    bit         in_frame = 1'b0;
    int         bit_idx = 0;
    int         byte_idx = 0;
    logic [7:0] shreg;
    logic [7:0] frame [3];
    int         ack_count = 0;
    int         ack_base = 0;
    int         nack_slot = 0;

    cam_cfg_top DUT (
        .i_clk    (clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_sda    (i_sda),
        .o_scl_oe (o_scl_oe),
        .o_sda_oe (o_sda_oe),
        .o_busy   (o_busy),
        .o_done   (o_done),
        .o_nack   (o_nack)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_value(input string msg, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got 0x%0h expected 0x%0h", $time, msg, got, exp);
            mismatch_count++;
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int nbits, output int val);
        int i;
        val = 0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | lfsr_state[0];
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int    fd;
        string line;
        byte   tag;
        int    a;
        int    b;
        int    n;
        ok = 1'b0;
        fd = $fopen("sim/cam_cfg_input.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/cam_cfg_input.txt");
            other_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // comments and blank lines
                if (line.len() < 2 || line[0] == "#" || line[0] == "\n") begin
                    continue;
                end
                tag = line[0];
                if (tag == "R") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%d %d", a, b);
                end else begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                end
                if (n == 2 && tag == "R") begin
                    run_nack.push_back(a);
                    run_busy.push_back(b != 0);
                end else if (n == 2 && tag == "W") begin
                    exp_reg.push_back(a[7:0]);
                    exp_val.push_back(b[7:0]);
                end else begin
                    $display("input file line not understood: %s", line);
                    other_count++;
                end
            end
            $fclose(fd);
            if (exp_reg.size() != 12) begin
                $display("input file holds %0d expected writes instead of 12", exp_reg.size());
                other_count++;
            end else if (run_nack.size() == 0) begin
                $display("input file holds no start requests");
                other_count++;
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    // one start request and the full table walk behind it
    task automatic run_table(input int idx);
        int          gap;
        int          i;
        int          done_before;
        logic [7:0]  slave_byte;
        // camera address 0x21 with the write bit low
        slave_byte = 8'h42;
        draw_bits(6, gap);
        repeat (gap + 2) @(posedge clk);
        nack_slot   = run_nack[idx];
        ack_base    = ack_count;
        done_before = done_count;
        txn_q.delete();
        first_start_sent = 1'b1;
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        while (!o_busy) @(posedge clk);
        // accepted start wipes the sticky nack
        check_value($sformatf("run %0d nack after start", idx), o_nack, 1'b0);
        if (run_busy[idx]) begin
            // strobe again mid-table, must be ignored
            while (txn_q.size() < 6) @(posedge clk);
            draw_bits(4, gap);
            repeat (gap) @(posedge clk);
            i_start <= 1'b1;
            @(posedge clk);
            i_start <= 1'b0;
        end
        while (!o_done) @(posedge clk);
        check_value($sformatf("run %0d writes before done", idx), txn_q.size(), 12);
        check_value($sformatf("run %0d busy with done", idx), o_busy, 1'b0);
        check_value($sformatf("run %0d nack flag", idx), o_nack, nack_slot != 0);
        for (i = 0; i < txn_q.size() && i < 12; i++) begin
            check_value($sformatf("run %0d write %0d slave byte", idx, i),
                        txn_q[i][23:16], slave_byte);
            check_value($sformatf("run %0d write %0d register", idx, i),
                        txn_q[i][15:8], exp_reg[i]);
            check_value($sformatf("run %0d write %0d value", idx, i),
                        txn_q[i][7:0], exp_val[i]);
        end
        // quiet bus after done, single pulse
        repeat (64) @(posedge clk);
        check_value($sformatf("run %0d done pulses", idx), done_count - done_before, 1);
        check_value($sformatf("run %0d writes after done", idx), txn_q.size(), 12);
        check_value($sformatf("run %0d busy after done", idx), o_busy, 1'b0);
    endtask

    // open-drain bus slave, follows the enables
    always @(posedge clk) begin
        scl_now = !o_scl_oe;
        sda_now = !(o_sda_oe || !i_sda);
        if (!i_rst) begin
            if (scl_now && scl_prev && sda_prev && !sda_now) begin
                // start condition
                in_frame = 1'b1;
                bit_idx  = 0;
                byte_idx = 0;
            end else if (scl_now && scl_prev && !sda_prev && sda_now) begin
                // stop condition
                if (in_frame && byte_idx != 3) begin
                    $display("stop condition after %0d bytes at %0t", byte_idx, $time);
                    other_count++;
                end else if (in_frame) begin
                    txn_q.push_back({frame[0], frame[1], frame[2]});
                end
                in_frame = 1'b0;
            end else if (in_frame && scl_now && !scl_prev) begin
                if (bit_idx < 8) begin
                    shreg = {shreg[6:0], sda_now};
                end else begin
                    if (byte_idx < 3) begin
                        frame[byte_idx] = shreg;
                    end
                    byte_idx++;
                end
                bit_idx = (bit_idx == 8) ? 0 : bit_idx + 1;
            end else if (in_frame && !scl_now && scl_prev) begin
                // pull low across the ack slot unless marked for nack
                if (bit_idx == 8) begin
                    ack_count++;
                    if (nack_slot != 0 && ack_count - ack_base == nack_slot) begin
                        i_sda <= 1'b1;
                    end else begin
                        i_sda <= 1'b0;
                    end
                end else begin
                    i_sda <= 1'b1;
                end
            end
        end
        scl_prev = scl_now;
        sda_prev = sda_now;
    end

    always @(posedge clk) begin
        if (o_done) begin
            done_count++;
        end
    end

    // quiet outputs from reset release to the first start
    always @(posedge clk) begin
        if (!i_rst && !first_start_sent) begin
            check_value("idle scl enable", o_scl_oe, 1'b0);
            check_value("idle sda enable", o_sda_oe, 1'b0);
            check_value("idle busy", o_busy, 1'b0);
            check_value("idle done", o_done, 1'b0);
            check_value("idle nack", o_nack, 1'b0);
        end
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, no done from the DUT within %0d cycles", cycle_limit);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        bit ok;
        int r;
        i_rst   = 1'b1;
        i_start = 1'b0;
        i_sda   = 1'b1;
        load_stimulus(ok);
        if (ok) begin
            // runs x transactions x bits x cycles per bit, doubled
            cycle_limit = run_nack.size() * 13 * 30 * 2 * SCL_HALF * 2;
            repeat (16) @(posedge clk);
            i_rst <= 1'b0;
            for (r = 0; r < run_nack.size(); r++) begin
                run_table(r);
            end
        end
        $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/cam_cfg_input.txt ====
# R <nack ack slot 1..36, 0 for none, decimal> <1 = start again while busy>
# W <register hex> <value hex>, expected writes in bus order
R 0 0
R 5 1
R 0 0
R 36 0
R 0 1
W 12 80
W 11 01
W 0C 04
W 3E 19
W 70 3A
W 71 35
W 72 11
W 73 F1
W A2 02
W 12 04
W 40 D0
W 8C 00

// ==== flist.f ====
hw/cam_cfg_pkg.sv
hw/cam_cfg_rom.sv
hw/cam_cfg_seq.sv
hw/cmd_fifo.sv
hw/sccb_master.sv
hw/cam_cfg_top.sv
sim/tb_cam_cfg.sv

// ==== Bender.yml ====
package:
  name: cam_cfg

sources:
  # shared package first
  - hw/cam_cfg_pkg.sv
  - hw/cam_cfg_rom.sv
  - hw/cam_cfg_seq.sv
  - hw/cmd_fifo.sv
  - hw/sccb_master.sv
  - hw/cam_cfg_top.sv

  - target: simulation
    files:
      - sim/tb_cam_cfg.sv
